/* hdl/calc_pkg.sv */
// Shared widths, operation codes, packet structs and pipe latencies of the execution core
`default_nettype none

package calc_pkg;

  localparam int data_width_gp     = 32;
  localparam int reg_addr_width_gp = 5;

  // Completion pipe depth and the stage where multiply results land
  localparam int comp_stages_gp    = 3;
  localparam int mul_land_stage_gp = 2;

  typedef logic [data_width_gp-1:0]     data_t;
  typedef logic [reg_addr_width_gp-1:0] reg_addr_t;

  typedef enum logic [3:0]
  {
    op_add
    , op_sub
    , op_and
    , op_or
    , op_xor
    , op_sll
    , op_srl
    , op_sltu
    , op_mul
    , op_divu
    , op_remu
  } calc_op_e;

  typedef struct packed
  {
    calc_op_e  op;
    reg_addr_t rd;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    data_t     rs1;
    data_t     rs2;
  } dispatch_pkt_t;

  typedef struct packed
  {
    calc_op_e  op;
    reg_addr_t rd;
    data_t     a;
    data_t     b;
  } exec_req_t;

  // w_v marks a pending register write, data_v marks data that is final
  typedef struct packed
  {
    logic      w_v;
    logic      data_v;
    reg_addr_t rd;
    data_t     data;
  } comp_entry_t;

  typedef struct packed
  {
    reg_addr_t rd;
    data_t     data;
  } wb_pkt_t;

  typedef enum logic [1:0]
  {
    div_idle
    , div_busy
    , div_done
  } div_state_e;

endpackage

`default_nettype wire

/* hdl/calc_int_pipe.sv */
// Single-cycle integer ALU evaluated combinationally in the issue cycle
`timescale 1ns/1ps
`default_nettype none

module calc_int_pipe
  import calc_pkg::*;
 (input  exec_req_t req_i
  , output data_t   result_o
  );

  logic [4:0] shamt;

  assign shamt = req_i.b[4:0];

  always_comb
    begin
      case (req_i.op)
        op_add  : result_o = req_i.a + req_i.b;
        op_sub  : result_o = req_i.a - req_i.b;
        op_and  : result_o = req_i.a & req_i.b;
        op_or   : result_o = req_i.a | req_i.b;
        op_xor  : result_o = req_i.a ^ req_i.b;
        op_sll  : result_o = req_i.a << shamt;
        op_srl  : result_o = req_i.a >> shamt;
        op_sltu : result_o = {{(data_width_gp-1){1'b0}}, (req_i.a < req_i.b)};
        // Multiply and divide results come from their own pipes
        default : result_o = '0;
      endcase
    end

endmodule

`default_nettype wire

/* hdl/calc_mul_pipe.sv */
// Two-register multiplier whose product meets its entry at the landing completion stage
`timescale 1ns/1ps
`default_nettype none

module calc_mul_pipe
  import calc_pkg::*;
 (input  logic        clk_i
  , input  logic      reset_i

  , input  logic      v_i
  , input  exec_req_t req_i

  , output logic      mul_v_o
  , output data_t     mul_data_o
  );

  logic  op_v_r, prod_v_r;
  data_t a_r, b_r;
  data_t prod, prod_r;

  // Only the low word of the product is kept
  assign prod = a_r * b_r;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          op_v_r   <= 1'b0;
          prod_v_r <= 1'b0;
        end
      else
        begin
          op_v_r   <= v_i;
          prod_v_r <= op_v_r;
        end
    end

  always_ff @(posedge clk_i)
    begin
      a_r    <= req_i.a;
      b_r    <= req_i.b;
      prod_r <= prod;
    end

  assign mul_v_o    = prod_v_r;
  assign mul_data_o = prod_r;

endmodule

`default_nettype wire

/* hdl/calc_div_pipe.sv */
// Iterative restoring unsigned divider that holds its result until writeback takes it
`timescale 1ns/1ps
`default_nettype none

module calc_div_pipe
  import calc_pkg::*;
 (input  logic        clk_i
  , input  logic      reset_i

  , input  logic      v_i
  , input  exec_req_t req_i
  , output logic      ready_o

  , output logic      busy_o
  , output reg_addr_t pending_rd_o

  , output logic      res_v_o
  , output wb_pkt_t   res_o
  , input  logic      res_ready_i
  );

  localparam int cnt_width_lp = $clog2(data_width_gp);
  localparam logic [cnt_width_lp-1:0] last_cnt_lp = cnt_width_lp'(data_width_gp - 1);

  div_state_e              state_r;
  logic [cnt_width_lp-1:0] cnt_r;
  data_t                   quot_r, rem_r, divisor_r;
  reg_addr_t               rd_r;
  logic                    is_rem_r;
  logic [data_width_gp:0]  shift_rem, sub_rem;
  logic                    fits, accept;

  assign accept = v_i & ready_o;

  // One quotient bit per cycle, dividend shifts out of the quotient register
  assign shift_rem = {rem_r, quot_r[data_width_gp-1]};
  assign sub_rem   = shift_rem - {1'b0, divisor_r};
  assign fits      = (shift_rem >= {1'b0, divisor_r});

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          state_r <= div_idle;
          cnt_r   <= '0;
        end
      else
        begin
          case (state_r)
            div_idle:
              if (accept)
                begin
                  state_r <= div_busy;
                  cnt_r   <= '0;
                end
            div_busy:
              begin
                cnt_r <= cnt_r + 1'b1;
                if (cnt_r == last_cnt_lp)
                  state_r <= div_done;
              end
            div_done:
              if (res_ready_i)
                state_r <= div_idle;
            default:
              state_r <= div_idle;
          endcase
        end
    end

  // A zero divisor always fits, giving all ones and the dividend as remainder
  always_ff @(posedge clk_i)
    begin
      if (accept)
        begin
          quot_r    <= req_i.a;
          rem_r     <= '0;
          divisor_r <= req_i.b;
          rd_r      <= req_i.rd;
          is_rem_r  <= (req_i.op == op_remu);
        end
      else if (state_r == div_busy)
        begin
          quot_r <= {quot_r[data_width_gp-2:0], fits};
          rem_r  <= fits ? sub_rem[data_width_gp-1:0] : shift_rem[data_width_gp-1:0];
        end
    end

  assign ready_o      = (state_r == div_idle);
  assign busy_o       = (state_r != div_idle);
  assign pending_rd_o = rd_r;
  assign res_v_o      = (state_r == div_done);
  assign res_o        = '{rd: rd_r, data: is_rem_r ? rem_r : quot_r};

endmodule

`default_nettype wire

/* hdl/calc_comp_stage.sv */
// One completion pipe stage that registers its entry and merges multiply data when it lands here
`timescale 1ns/1ps
`default_nettype none

module calc_comp_stage
  import calc_pkg::*;
 #(parameter int stage_index_p = 0)
 (input  logic          clk_i
  , input  logic        reset_i

  , input  comp_entry_t entry_i

  , input  logic        mul_v_i
  , input  data_t       mul_data_i

  , output comp_entry_t entry_o
  );

  localparam logic land_lp = (stage_index_p == mul_land_stage_gp);

  comp_entry_t entry_n;
  logic        w_v_r, data_v_r;
  reg_addr_t   rd_r;
  data_t       data_r;

  always_comb
    begin
      entry_n = entry_i;
      if (land_lp && mul_v_i && entry_i.w_v && !entry_i.data_v)
        begin
          entry_n.data   = mul_data_i;
          entry_n.data_v = 1'b1;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        begin
          w_v_r    <= 1'b0;
          data_v_r <= 1'b0;
        end
      else
        begin
          w_v_r    <= entry_n.w_v;
          data_v_r <= entry_n.data_v;
        end
    end

  always_ff @(posedge clk_i)
    begin
      rd_r   <= entry_n.rd;
      data_r <= entry_n.data;
    end

  assign entry_o = '{w_v: w_v_r, data_v: data_v_r, rd: rd_r, data: data_r};

endmodule

`default_nettype wire

/* hdl/calc_writeback.sv */
// Writeback port that merges the completion pipe with divider results into one register
`timescale 1ns/1ps
`default_nettype none

module calc_writeback
  import calc_pkg::*;
 (input  logic          clk_i
  , input  logic        reset_i

  , input  comp_entry_t last_entry_i

  , input  logic        div_res_v_i
  , input  wb_pkt_t     div_res_i
  , output logic        div_res_ready_o

  , output logic        wb_v_o
  , output wb_pkt_t     wb_pkt_o
  );

  logic    take_div;
  logic    wb_v_r;
  wb_pkt_t wb_pkt_r;

  // The divider only gets slots the completion pipe leaves empty
  assign div_res_ready_o = ~last_entry_i.w_v;
  assign take_div        = div_res_v_i & div_res_ready_o;

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        wb_v_r <= 1'b0;
      else
        wb_v_r <= last_entry_i.w_v | take_div;
    end

  always_ff @(posedge clk_i)
    begin
      if (last_entry_i.w_v)
        wb_pkt_r <= '{rd: last_entry_i.rd, data: last_entry_i.data};
      else
        wb_pkt_r <= div_res_i;
    end

  assign wb_v_o   = wb_v_r;
  assign wb_pkt_o = wb_pkt_r;

endmodule

`default_nettype wire

/* hdl/calc_dispatch.sv */
// Reservation register with operand bypass and hazard checks that issues one op per cycle
`timescale 1ns/1ps
`default_nettype none

module calc_dispatch
  import calc_pkg::*;
 (input  logic                           clk_i
  , input  logic                         reset_i

  , input  logic                         dispatch_v_i
  , input  dispatch_pkt_t                dispatch_pkt_i
  , output logic                         dispatch_ready_o

  , input  comp_entry_t [comp_stages_gp:0] stage_entries_i

  , input  logic                         div_busy_i
  , input  reg_addr_t                    div_rd_i
  , input  logic                         div_ready_i

  , input  data_t                        int_result_i
  , output exec_req_t                    issue_req_o
  , output logic                         mul_v_o
  , output logic                         div_v_o
  , output comp_entry_t                  entry_o
  );

  dispatch_pkt_t res_r, res_n;
  logic          res_v_r;
  comp_entry_t   byp_rs1, byp_rs2;
  comp_entry_t   new_rs1, new_rs2;
  logic          is_mul, is_div;
  logic          data_hazard, div_hazard, div_wait;
  logic          issue, accept;

  // Youngest writer wins since lower indices are visited last
  function automatic comp_entry_t bypass(reg_addr_t addr, data_t dflt,
                                         comp_entry_t [comp_stages_gp:0] entries);
    comp_entry_t sel;
    int          i;
    sel = '{w_v: 1'b0, data_v: 1'b1, rd: addr, data: dflt};
    for (i = comp_stages_gp; i >= 0; i--)
      begin
        if (entries[i].w_v && (entries[i].rd == addr))
          sel = entries[i];
      end
    return sel;
  endfunction

  assign byp_rs1 = bypass(res_r.rs1_addr, res_r.rs1, stage_entries_i);
  assign byp_rs2 = bypass(res_r.rs2_addr, res_r.rs2, stage_entries_i);
  assign new_rs1 = bypass(dispatch_pkt_i.rs1_addr, dispatch_pkt_i.rs1, stage_entries_i);
  assign new_rs2 = bypass(dispatch_pkt_i.rs2_addr, dispatch_pkt_i.rs2, stage_entries_i);

  assign is_mul = (res_r.op == op_mul);
  assign is_div = (res_r.op == op_divu) | (res_r.op == op_remu);

  // A matching multiply that has not reached its landing stage yet
  assign data_hazard = (byp_rs1.w_v & ~byp_rs1.data_v) | (byp_rs2.w_v & ~byp_rs2.data_v);
  assign div_hazard  = div_busy_i & ((res_r.rs1_addr == div_rd_i)
                                     | (res_r.rs2_addr == div_rd_i)
                                     | (res_r.rd == div_rd_i));
  assign div_wait    = is_div & ~div_ready_i;

  assign issue            = res_v_r & ~data_hazard & ~div_hazard & ~div_wait;
  assign dispatch_ready_o = ~res_v_r | issue;
  assign accept           = dispatch_v_i & dispatch_ready_o;

  assign issue_req_o = '{op: res_r.op, rd: res_r.rd, a: byp_rs1.data, b: byp_rs2.data};
  assign mul_v_o     = issue & is_mul;
  assign div_v_o     = issue & is_div;

  // Divide results bypass the completion pipe so their entry never writes
  assign entry_o = '{w_v    : issue & ~is_div
                    , data_v: ~is_mul
                    , rd    : res_r.rd
                    , data  : int_result_i
                    };

  // A waiting op keeps picking up results as they drain toward the register file
  always_comb
    begin
      res_n = res_r;
      if (accept)
        begin
          res_n     = dispatch_pkt_i;
          res_n.rs1 = new_rs1.data;
          res_n.rs2 = new_rs2.data;
        end
      else
        begin
          res_n.rs1 = byp_rs1.data;
          res_n.rs2 = byp_rs2.data;
        end
    end

  always_ff @(posedge clk_i)
    begin
      if (reset_i)
        res_v_r <= 1'b0;
      else if (accept)
        res_v_r <= 1'b1;
      else if (issue)
        res_v_r <= 1'b0;
    end

  always_ff @(posedge clk_i)
    begin
      res_r <= res_n;
    end

endmodule

`default_nettype wire

/* hdl/calc_top.sv */
// Integer execution core top connecting dispatch, execution pipes, completion pipe and writeback
`timescale 1ns/1ps
`default_nettype none

module calc_top
  import calc_pkg::*;
 (input  logic            clk_i
  , input  logic          reset_i

  // Operands must reflect the register file in the cycle they are accepted
  , input  logic          dispatch_v_i
  , input  dispatch_pkt_t dispatch_pkt_i
  , output logic          dispatch_ready_o

  , output logic          wb_v_o
  , output wb_pkt_t       wb_pkt_o
  );

  comp_entry_t [comp_stages_gp:0] chain;
  comp_entry_t [comp_stages_gp:0] bypass_entries;
  comp_entry_t                    wb_entry;
  exec_req_t                      issue_req;
  data_t                          int_result, mul_data;
  logic                           mul_v, div_v, mul_res_v;
  logic                           div_ready, div_busy, div_res_v, div_res_ready;
  reg_addr_t                      div_rd;
  wb_pkt_t                        div_res;

  // The writeback register is the oldest bypass source
  assign wb_entry       = '{w_v: wb_v_o, data_v: 1'b1, rd: wb_pkt_o.rd, data: wb_pkt_o.data};
  assign bypass_entries = {wb_entry, chain[comp_stages_gp:1]};

  calc_dispatch dispatch
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.dispatch_ready_o(dispatch_ready_o)
     ,.stage_entries_i(bypass_entries)
     ,.div_busy_i(div_busy)
     ,.div_rd_i(div_rd)
     ,.div_ready_i(div_ready)
     ,.int_result_i(int_result)
     ,.issue_req_o(issue_req)
     ,.mul_v_o(mul_v)
     ,.div_v_o(div_v)
     ,.entry_o(chain[0])
     );

  calc_int_pipe int_pipe
    (.req_i(issue_req)
     ,.result_o(int_result)
     );

  calc_mul_pipe mul_pipe
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(mul_v)
     ,.req_i(issue_req)
     ,.mul_v_o(mul_res_v)
     ,.mul_data_o(mul_data)
     );

  calc_div_pipe div_pipe
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.v_i(div_v)
     ,.req_i(issue_req)
     ,.ready_o(div_ready)
     ,.busy_o(div_busy)
     ,.pending_rd_o(div_rd)
     ,.res_v_o(div_res_v)
     ,.res_o(div_res)
     ,.res_ready_i(div_res_ready)
     );

  for (genvar i = 0; i < comp_stages_gp; i++)
    begin : comp_stage
      calc_comp_stage #(.stage_index_p(i)) stage
        (.clk_i(clk_i)
         ,.reset_i(reset_i)
         ,.entry_i(chain[i])
         ,.mul_v_i(mul_res_v)
         ,.mul_data_i(mul_data)
         ,.entry_o(chain[i+1])
         );
    end

  calc_writeback writeback
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.last_entry_i(chain[comp_stages_gp])
     ,.div_res_v_i(div_res_v)
     ,.div_res_i(div_res)
     ,.div_res_ready_o(div_res_ready)
     ,.wb_v_o(wb_v_o)
     ,.wb_pkt_o(wb_pkt_o)
     );

endmodule

`default_nettype wire

/* testbench/calc_checker.sv */
// Program-order reference model that checks every writeback of the core and keeps the counts
`timescale 1ns/1ps
`default_nettype none

module calc_checker
  import calc_pkg::*;
 (input  logic                  clk_i
  , input  logic                reset_i
  , input  data_t [31:0]        init_regs_i

  , input  logic                dispatch_v_i
  , input  logic                dispatch_ready_i
  , input  dispatch_pkt_t       dispatch_pkt_i
  , input  logic [127:0]        name_i

  , input  logic                wb_v_i
  , input  wb_pkt_t             wb_pkt_i

  , output int                  errors_o
  , output int                  checks_o
  , output int                  accepted_o
  , output int                  writebacks_o
  , output int                  pending_o
  );

  typedef struct packed
  {
    reg_addr_t    rd;
    data_t        data;
    logic [127:0] name;
  } expect_t;

  data_t [31:0] ref_regs;
  expect_t      pend_q[$];
  int           errors, checks, accepted, writebacks;
  logic         after_reset;

  function automatic data_t expected_result(calc_op_e op, data_t a, data_t b);
    data_t r;
    case (op)
      op_add  : r = a + b;
      op_sub  : r = a - b;
      op_and  : r = a & b;
      op_or   : r = a | b;
      op_xor  : r = a ^ b;
      op_sll  : r = a << b[4:0];
      op_srl  : r = a >> b[4:0];
      op_sltu : r = (a < b) ? data_t'(1) : data_t'(0);
      op_mul  : r = a * b;
      // Zero divisor gives all ones and the dividend as remainder
      op_divu : r = (b == 0) ? {data_width_gp{1'b1}} : a / b;
      op_remu : r = (b == 0) ? a : a % b;
      default : r = '0;
    endcase
    return r;
  endfunction

  // Oldest outstanding write to this register
  function automatic int find_pending(reg_addr_t rd);
    int i;
    int found;
    found = -1;
    for (i = 0; i < pend_q.size(); i++)
      begin
        if (found < 0 && pend_q[i].rd == rd)
          found = i;
      end
    return found;
  endfunction

  always @(posedge clk_i)
    begin : watch
      int      idx;
      expect_t exp_e;
      if (reset_i)
        begin
          ref_regs = init_regs_i;
          pend_q.delete();
          errors      = 0;
          checks      = 0;
          accepted    = 0;
          writebacks  = 0;
          after_reset = 1'b1;
        end
      else
        begin
          if (after_reset && !dispatch_ready_i)
            begin
              $display("dispatch_ready_o is low in the first cycle after reset");
              errors++;
            end
          after_reset = 1'b0;
          if (wb_v_i)
            begin
              writebacks++;
              idx = find_pending(wb_pkt_i.rd);
              if (idx < 0)
                begin
                  $display("Unexpected writeback to r%0d with data %h", wb_pkt_i.rd, wb_pkt_i.data);
                  errors++;
                end
              else
                begin
                  exp_e = pend_q[idx];
                  pend_q.delete(idx);
                  checks++;
                  if (wb_pkt_i.data !== exp_e.data)
                    begin
                      $display("FAIL %0s r%0d expected %h actual %h",
                               exp_e.name, exp_e.rd, exp_e.data, wb_pkt_i.data);
                      errors++;
                    end
                  else
                    $display("PASS %0s r%0d = %h", exp_e.name, exp_e.rd, wb_pkt_i.data);
                end
            end
          if (dispatch_v_i && dispatch_ready_i)
            begin
              accepted++;
              exp_e.rd   = dispatch_pkt_i.rd;
              exp_e.name = name_i;
              exp_e.data = expected_result(dispatch_pkt_i.op,
                                           ref_regs[dispatch_pkt_i.rs1_addr],
                                           ref_regs[dispatch_pkt_i.rs2_addr]);
              ref_regs[dispatch_pkt_i.rd] = exp_e.data;
              pend_q.push_back(exp_e);
            end
        end
      errors_o     <= errors;
      checks_o     <= checks;
      accepted_o   <= accepted;
      writebacks_o <= writebacks;
      pending_o    <= pend_q.size();
    end

endmodule

`default_nettype wire

/* testbench/calc_tb.sv */
// Testbench for the execution core that applies a table of instructions and reports the result
`timescale 1ns/1ps
`default_nettype none

module calc_tb
  import calc_pkg::*;
 ();

  localparam int clk_period_lp    = 40;
  localparam int ready_timeout_lp = 200;
  localparam int drain_timeout_lp = 400;
  localparam int random_count_lp  = 40;

  typedef struct packed
  {
    calc_op_e     op;
    reg_addr_t    rd;
    reg_addr_t    rs1;
    reg_addr_t    rs2;
    logic [127:0] name;
  } stim_t;

  logic          clk_i, reset_i;
  logic          dispatch_v_i, dispatch_ready_o;
  dispatch_pkt_t dispatch_pkt_i;
  logic          wb_v_o;
  wb_pkt_t       wb_pkt_o;
  logic [127:0]  test_name;
  data_t [31:0]  init_regs, regs;
  stim_t         stim_q[$];
  int            seed, tb_errors;
  logic          timed_out;
  int            errors_seen, checks_seen, accepted_seen, writebacks_seen, pending_seen;

  calc_top calc_top_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.dispatch_v_i(dispatch_v_i)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.dispatch_ready_o(dispatch_ready_o)
     ,.wb_v_o(wb_v_o)
     ,.wb_pkt_o(wb_pkt_o)
     );

  calc_checker check
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.init_regs_i(init_regs)
     ,.dispatch_v_i(dispatch_v_i)
     ,.dispatch_ready_i(dispatch_ready_o)
     ,.dispatch_pkt_i(dispatch_pkt_i)
     ,.name_i(test_name)
     ,.wb_v_i(wb_v_o)
     ,.wb_pkt_i(wb_pkt_o)
     ,.errors_o(errors_seen)
     ,.checks_o(checks_seen)
     ,.accepted_o(accepted_seen)
     ,.writebacks_o(writebacks_seen)
     ,.pending_o(pending_seen)
     );

  initial
    begin
      clk_i = 1'b0;
      forever #(clk_period_lp/2) clk_i = ~clk_i;
    end

  // Register file model written from the writeback port
  always @(posedge clk_i)
    begin
      if (reset_i)
        regs <= init_regs;
      else if (wb_v_o)
        regs[wb_pkt_o.rd] <= wb_pkt_o.data;
    end

  // Register contents once the write at this edge has landed
  function automatic data_t read_operand(reg_addr_t addr);
    if (wb_v_o && wb_pkt_o.rd == addr)
      return wb_pkt_o.data;
    return regs[addr];
  endfunction

  task automatic add_row(input calc_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                         input reg_addr_t rs2, input logic [127:0] name);
    stim_t row;
    row = '{op: op, rd: rd, rs1: rs1, rs2: rs2, name: name};
    stim_q.push_back(row);
  endtask

  task automatic drive_row(input stim_t row);
    dispatch_pkt_t pkt;
    pkt.op       = row.op;
    pkt.rd       = row.rd;
    pkt.rs1_addr = row.rs1;
    pkt.rs2_addr = row.rs2;
    pkt.rs1      = read_operand(row.rs1);
    pkt.rs2      = read_operand(row.rs2);
    dispatch_pkt_i <= pkt;
    test_name      <= row.name;
    dispatch_v_i   <= 1'b1;
  endtask

  // Operands are refreshed every cycle the core holds the row back
  task automatic apply_table();
    int    waits;
    stim_t row;
    for (int n = 0; n < stim_q.size() && !timed_out; n++)
      begin
        row = stim_q[n];
        drive_row(row);
        waits = 0;
        @(posedge clk_i);
        while (!dispatch_ready_o && waits < ready_timeout_lp)
          begin
            drive_row(row);
            waits++;
            @(posedge clk_i);
          end
        if (!dispatch_ready_o)
          begin
            $display("Timeout: dispatch_ready_o stayed low for %0d cycles on row %0d (%0s)",
                     waits, n, row.name);
            tb_errors++;
            timed_out = 1'b1;
          end
      end
    dispatch_v_i <= 1'b0;
  endtask

  task automatic wait_drain();
    int waits;
    waits = 0;
    @(posedge clk_i);
    while (pending_seen != 0 && waits < drain_timeout_lp)
      begin
        waits++;
        @(posedge clk_i);
      end
    if (pending_seen != 0)
      begin
        $display("Timeout: %0d expected writebacks never arrived", pending_seen);
        tb_errors++;
      end
  endtask

  initial
    begin
      int i;
      int total_errors;
      clk_i          = 1'b0;
      reset_i        = 1'b1;
      dispatch_v_i   = 1'b0;
      dispatch_pkt_i = '0;
      test_name      = '0;
      tb_errors      = 0;
      timed_out      = 1'b0;
      seed           = 47;
      for (i = 0; i < 32; i++)
        init_regs[i] = $random(seed);

      add_row(op_add,  5'd1,  5'd20, 5'd21, "alu_add");
      add_row(op_sub,  5'd2,  5'd22, 5'd23, "alu_sub");
      add_row(op_and,  5'd3,  5'd24, 5'd25, "alu_and");
      add_row(op_or,   5'd4,  5'd26, 5'd27, "alu_or");
      add_row(op_xor,  5'd5,  5'd20, 5'd22, "alu_xor");
      add_row(op_sll,  5'd6,  5'd21, 5'd23, "alu_sll");
      add_row(op_srl,  5'd7,  5'd24, 5'd26, "alu_srl");
      add_row(op_sltu, 5'd8,  5'd25, 5'd27, "alu_sltu");
      // Each row reads what the one before it just produced
      add_row(op_add,  5'd9,  5'd20, 5'd21, "chain_head");
      add_row(op_sub,  5'd10, 5'd9,  5'd22, "chain_sub");
      add_row(op_xor,  5'd9,  5'd10, 5'd9,  "chain_xor");
      add_row(op_add,  5'd11, 5'd9,  5'd10, "chain_add");
      add_row(op_sll,  5'd12, 5'd11, 5'd9,  "chain_sll");
      add_row(op_or,   5'd13, 5'd12, 5'd11, "chain_or");
      add_row(op_mul,  5'd14, 5'd20, 5'd21, "mul_producer");
      add_row(op_add,  5'd15, 5'd14, 5'd22, "mul_consumer");
      add_row(op_mul,  5'd16, 5'd23, 5'd24, "mul_pair_a");
      add_row(op_mul,  5'd17, 5'd25, 5'd26, "mul_pair_b");
      add_row(op_sub,  5'd18, 5'd17, 5'd16, "mul_pair_use");
      add_row(op_divu, 5'd19, 5'd20, 5'd21, "divu");
      add_row(op_add,  5'd28, 5'd22, 5'd23, "div_overtake_a");
      add_row(op_xor,  5'd29, 5'd24, 5'd25, "div_overtake_b");
      add_row(op_add,  5'd30, 5'd19, 5'd22, "div_raw_wait");
      add_row(op_remu, 5'd31, 5'd20, 5'd21, "remu");
      add_row(op_or,   5'd31, 5'd26, 5'd27, "div_waw_wait");
      add_row(op_sub,  5'd0,  5'd20, 5'd20, "zero_setup");
      add_row(op_divu, 5'd1,  5'd22, 5'd0,  "divu_by_zero");
      add_row(op_remu, 5'd2,  5'd23, 5'd0,  "remu_by_zero");
      add_row(op_sltu, 5'd3,  5'd2,  5'd1,  "div_result_use");
      for (i = 0; i < random_count_lp; i++)
        add_row(calc_op_e'(4'($unsigned($random(seed)) % 11)), reg_addr_t'($random(seed)),
                reg_addr_t'($random(seed)), reg_addr_t'($random(seed)), "random");

      repeat (2) @(posedge clk_i);
      reset_i <= 1'b0;
      // A few idle cycles in which no writeback may appear
      repeat (4) @(posedge clk_i);
      apply_table();
      if (!timed_out)
        wait_drain();
      @(posedge clk_i);

      total_errors = tb_errors + errors_seen;
      if (writebacks_seen != accepted_seen)
        begin
          $display("Writeback count %0d does not match %0d accepted instructions",
                   writebacks_seen, accepted_seen);
          total_errors++;
        end
      $display("Counts: %0d accepted, %0d writebacks, %0d checked, %0d errors",
               accepted_seen, writebacks_seen, checks_seen, total_errors);
      if (total_errors == 0)
        $display("Finished with no errors");
      else
        $display("Finished with errors");
      $finish;
    end

endmodule

`default_nettype wire

/* calc_top.f */
hdl/calc_pkg.sv
hdl/calc_int_pipe.sv
hdl/calc_mul_pipe.sv
hdl/calc_div_pipe.sv
hdl/calc_comp_stage.sv
hdl/calc_writeback.sv
hdl/calc_dispatch.sv
hdl/calc_top.sv
testbench/calc_checker.sv
testbench/calc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal --top-module calc_tb -f calc_top.f -o calc_sim \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/calc_sim > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log
grep -qx "Finished with no errors" sim.log && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }
